//--- verilog.f
source/radar_pkg.sv
source/point_window.sv
source/median5.sv
source/clutter_remover.sv
source/doppler_velocity.sv
source/radar_filter.sv
tb/radar_filter_properties.sv
tb/radar_filter_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module radar_filter_tb -f verilog.f -o radar_filter_sim || exit 1

sim_output=$(./obj_dir/radar_filter_sim)
echo "$sim_output"

echo "$sim_output" | grep -qx "Simulation completed successfully" && exit 0 || exit 1

//--- tb/radar_filter_tb.sv
`timescale 1ns/1ps

module radar_filter_tb;

    localparam int NUM_ENTRIES  = 48;
    localparam int HAND_ENTRIES = 16;
    localparam int RESET_CYCLES = 10;
    localparam int LATENCY      = 3;
    localparam int DRAIN_STEPS  = LATENCY + 3;  // Extra steps catch stray strobes
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_ENTRIES + LATENCY + 20;

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    radar_pkg::point_t       in_point;
    logic                    out_valid;
    radar_pkg::cloud_point_t out_point;

    logic                    stim_valid     [NUM_ENTRIES];
    radar_pkg::point_t       stim_point     [NUM_ENTRIES];
    radar_pkg::cloud_point_t expected_point [NUM_ENTRIES];
    int                      expected_step  [NUM_ENTRIES]; // Step where out_valid is due
    int                      expected_count;

    logic [15:0] lfsr_state;
    int          mismatch_errors;
    int          other_errors;
    int          strobe_count;
    int          match_index;
    int          cycle_count = 0;

    radar_filter u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_point  (in_point),
        .out_valid (out_valid),
        .out_point (out_point)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Stimulus generation
    // ----------------------------------------------------------
    // Polynomial x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]}; // One step per bit
        end
    endtask

    task automatic set_entry(input int index, input logic valid, input int x, input int y,
                             input int z, input logic [15:0] phase,
                             input logic [15:0] intensity);
        stim_valid[index]                = valid;
        stim_point[index].x              = x;
        stim_point[index].y              = y;
        stim_point[index].z              = z;
        stim_point[index].attr.phase     = phase;
        stim_point[index].attr.intensity = intensity;
    endtask

    task automatic fill_hand_entries();
        set_entry(0,  1'b1, -100, 50, -7, 16'h0010, 16'h0300);
        set_entry(1,  1'b1, -90, 52, -6, 16'h0020, 16'h0010);
        set_entry(2,  1'b0, 0, 0, 0, 16'h0000, 16'h0000);           // Idle gap
        set_entry(3,  1'b1, -95, 51, -2000000000, 16'h0030, 16'h0100); // Negative spike
        set_entry(4,  1'b1, -80, 49, -5, 16'h0035, 16'h00FE);
        set_entry(5,  1'b1, -85, 53, -4, 16'h00F0, 16'h00FF);       // First output
        set_entry(6,  1'b1, 2000000000, 48, -3, 16'hFFFE, 16'hFFFF); // Positive spike
        set_entry(7,  1'b0, 0, 0, 0, 16'h0000, 16'h0000);
        set_entry(8,  1'b1, -70, 47, -2, 16'hFFFF, 16'h0000);
        set_entry(9,  1'b1, -75, 46, -1, 16'h0001, 16'h1234);       // Phase wrap gives +2
        set_entry(10, 1'b1, -60, 45, 0, 16'h0002, 16'h0001);
        set_entry(11, 1'b1, -65, -9999, 1, 16'h0080, 16'h8000);
        set_entry(12, 1'b1, -55, 44, 1, 16'h0180, 16'h00FF);        // Low byte zero
        set_entry(13, 1'b1, -50, 43, 2, 16'h0100, 16'h7FFF);        // Gives -128
        set_entry(14, 1'b0, 0, 0, 0, 16'h0000, 16'h0000);
        set_entry(15, 1'b1, -45, 42, 3, 16'h01FF, 16'h0002);
    endtask

    task automatic fill_random_entries();
        logic [31:0] flag_bits;
        logic [31:0] x_bits;
        logic [31:0] y_bits;
        logic [31:0] z_bits;
        logic [31:0] attr_bits;
        for (int i = HAND_ENTRIES; i < NUM_ENTRIES; i++) begin
            draw_bits(3, flag_bits);   // One idle entry in eight
            draw_bits(32, x_bits);
            draw_bits(32, y_bits);
            draw_bits(32, z_bits);
            draw_bits(32, attr_bits);
            set_entry(i, flag_bits != 0, x_bits, y_bits, z_bits, attr_bits[31:16],
                      attr_bits[15:0]);
        end
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic radar_pkg::coord_t median_of_five(input radar_pkg::coord_t samples [5]);
        radar_pkg::coord_t sorted [5];
        radar_pkg::coord_t temp;
        sorted = samples;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4 - i; j++) begin
                if (sorted[j] > sorted[j + 1]) begin
                    temp          = sorted[j];
                    sorted[j]     = sorted[j + 1];
                    sorted[j + 1] = temp;
                end
            end
        end
        return sorted[2];
    endfunction

    task automatic build_expected();
        radar_pkg::coord_t history    [3][5]; // Per axis with the oldest first
        radar_pkg::coord_t column     [5];
        radar_pkg::coord_t medians    [3];
        logic [15:0]       background [16];   // Raw intensities in ring order
        logic [15:0]       threshold;
        logic [15:0]       intensity;
        logic [15:0]       phase_diff;
        logic [15:0]       prev_phase;
        int                valid_seen;
        int                background_sum;
        int                low_bits;
        valid_seen     = 0;
        expected_count = 0;
        prev_phase     = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (stim_valid[i]) begin
                for (int a = 0; a < 3; a++) begin
                    for (int s = 0; s < 4; s++) begin
                        history[a][s] = history[a][s + 1];
                    end
                end
                history[0][4] = stim_point[i].x;
                history[1][4] = stim_point[i].y;
                history[2][4] = stim_point[i].z;
                valid_seen++;
                if (valid_seen >= 5) begin
                    for (int a = 0; a < 3; a++) begin
                        column     = history[a];
                        medians[a] = median_of_five(column);
                    end
                    intensity = stim_point[i].attr.intensity;
                    if (expected_count < 16) begin
                        threshold = 16'h00FF;
                    end else begin
                        background_sum = 0;
                        for (int k = 0; k < 16; k++) begin
                            background_sum += background[k];
                        end
                        threshold = 16'(background_sum / 16); // Floor of the mean
                    end
                    background[expected_count % 16] = intensity;
                    if (expected_count == 0) begin
                        low_bits = 0;
                    end else begin
                        phase_diff = stim_point[i].attr.phase - prev_phase; // Modulo 2^16
                        low_bits   = int'(phase_diff) % 256;
                        if (low_bits >= 128) begin
                            low_bits -= 256;
                        end
                    end
                    prev_phase = stim_point[i].attr.phase;
                    expected_point[expected_count].x         = medians[0];
                    expected_point[expected_count].y         = medians[1];
                    expected_point[expected_count].z         = medians[2];
                    expected_point[expected_count].intensity = (intensity < threshold)
                                                               ? 16'h0000 : intensity;
                    expected_point[expected_count].velocity  = 16'(low_bits);
                    expected_step[expected_count]            = i + LATENCY;
                    expected_count++;
                end
            end
        end
    endtask

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic report_mismatch(input string name, input int got, input int want);
        mismatch_errors++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
    endtask

    task automatic compare_point(input radar_pkg::cloud_point_t want);
        if (out_point.x !== want.x) begin
            report_mismatch("out_point.x", out_point.x, want.x);
        end
        if (out_point.y !== want.y) begin
            report_mismatch("out_point.y", out_point.y, want.y);
        end
        if (out_point.z !== want.z) begin
            report_mismatch("out_point.z", out_point.z, want.z);
        end
        if (out_point.intensity !== want.intensity) begin
            report_mismatch("out_point.intensity", out_point.intensity, want.intensity);
        end
        if (out_point.velocity !== want.velocity) begin
            report_mismatch("out_point.velocity", out_point.velocity, want.velocity);
        end
    endtask

    task automatic check_outputs(input int step);
        logic due;
        due = (match_index < expected_count) && (expected_step[match_index] == step);
        if (out_valid === 1'b1) begin
            strobe_count++;
        end
        if (out_valid !== due) begin
            mismatch_errors++;
            $display("mismatch at %0t: out_valid got %b expected %b", $time, out_valid, due);
        end
        if (due) begin
            if (out_valid === 1'b1) begin
                compare_point(expected_point[match_index]);
            end
            match_index++;
        end
    endtask

    initial begin
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_point        = '0;
        mismatch_errors = 0;
        other_errors    = 0;
        strobe_count    = 0;
        match_index     = 0;
        lfsr_state      = 16'd14712;
        fill_hand_entries();
        fill_random_entries();
        build_expected();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                mismatch_errors++;
                $display("mismatch at %0t: out_valid got %b expected 0 in reset", $time,
                         out_valid);
            end
        end
        reset = 1'b0;

        for (int step = 0; step < NUM_ENTRIES + DRAIN_STEPS; step++) begin
            @(negedge clk);
            check_outputs(step);       // Outputs settled since the rising edge
            if (step < NUM_ENTRIES) begin
                in_valid = stim_valid[step];
                in_point = stim_point[step];
            end else begin
                in_valid = 1'b0;
                in_point = '0;
            end
        end

        if (strobe_count != expected_count) begin
            other_errors++;
            $display("Wrong number of output points: saw %0d strobes but expected %0d",
                     strobe_count, expected_count);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog on total clock cycles
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

//--- tb/radar_filter_properties.sv
`timescale 1ns/1ps

module radar_filter_properties (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic window_valid,
    input logic clean_valid,
    input logic out_valid
);

    // ----------------------------------------------------------
    // Pipeline strobes
    // ----------------------------------------------------------
    no_output_in_reset: assert property (@(posedge clk) reset |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    // Fixed three-cycle latency from input to output
    output_follows_input: assert property (
        @(posedge clk) disable iff (reset) out_valid |-> $past(in_valid, 3))
        else $error("out_valid without an in_valid three cycles earlier");

    clean_follows_window: assert property (
        @(posedge clk) disable iff (reset) window_valid |=> clean_valid)
        else $error("clean_valid missing one cycle after window_valid");

endmodule

bind radar_filter radar_filter_properties u_properties (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .window_valid (window_valid),
    .clean_valid  (clean_valid),
    .out_valid    (out_valid)
);

//--- source/radar_filter.sv
`timescale 1ns/1ps

module radar_filter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  radar_pkg::point_t       in_point,
    output logic                    out_valid,
    output radar_pkg::cloud_point_t out_point
);

    radar_pkg::window_t                          window;
    logic                                        window_valid;
    radar_pkg::coord_t [radar_pkg::NUM_AXES-1:0] medians;        // 0 = X, 1 = Y, 2 = Z
    radar_pkg::point_t                           filtered_point; // Median point
    logic                                        clean_valid;
    radar_pkg::point_t                           clean_point;

    // ----------------------------------------------------------
    // Noise reduction
    // ----------------------------------------------------------
    point_window u_window (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_point     (in_point),
        .window       (window),
        .window_valid (window_valid)
    );

    for (genvar i = 0; i < radar_pkg::NUM_AXES; i++) begin : gen_median
        median5 u_median (
            .samples (window.axes[i]),
            .median  (medians[i])
        );
    end

    assign filtered_point.x    = medians[0];
    assign filtered_point.y    = medians[1];
    assign filtered_point.z    = medians[2];
    assign filtered_point.attr = window.attr; // Newest point's phase and intensity

    // ----------------------------------------------------------
    // Clutter removal and Doppler
    // ----------------------------------------------------------
    clutter_remover u_clutter (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (window_valid),
        .in_point    (filtered_point),
        .clean_valid (clean_valid),
        .clean_point (clean_point)
    );

    doppler_velocity u_doppler (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (clean_valid),
        .in_point  (clean_point),
        .out_valid (out_valid),
        .out_point (out_point)
    );

endmodule

//--- source/doppler_velocity.sv
`timescale 1ns/1ps

module doppler_velocity (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  radar_pkg::point_t       in_point,
    output logic                    out_valid,
    output radar_pkg::cloud_point_t out_point
);

    radar_pkg::phase_t    prev_phase; // Phase of the previous valid point
    logic                 have_phase; // Set once a point has been seen
    radar_pkg::phase_t    phase_diff; // Modulo 2^16 so wrap-around falls out
    radar_pkg::velocity_t velocity;

    assign phase_diff = in_point.attr.phase - prev_phase;

    // Sign-extended low bits of the difference and zero for the first point
    assign velocity = have_phase
                    ? radar_pkg::velocity_t'($signed(phase_diff[radar_pkg::VELOCITY_BITS-1:0]))
                    : '0;

    // ----------------------------------------------------------
    // Phase history and output packing
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_point  <= '0;
            prev_phase <= '0;
            have_phase <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_point.x         <= in_point.x;
                out_point.y         <= in_point.y;
                out_point.z         <= in_point.z;
                out_point.intensity <= in_point.attr.intensity; // Already gated
                out_point.velocity  <= velocity;
                prev_phase          <= in_point.attr.phase;
                have_phase          <= 1'b1;
            end
        end
    end

    // Idle cycles keep prev_phase, so the difference always spans
    // two consecutive valid points

endmodule

//--- source/clutter_remover.sv
`timescale 1ns/1ps

module clutter_remover (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  radar_pkg::point_t in_point,
    output logic              clean_valid,
    output radar_pkg::point_t clean_point
);

    radar_pkg::intensity_t history [radar_pkg::BACKGROUND_DEPTH]; // Raw intensity ring

    logic [radar_pkg::BACKGROUND_SHIFT-1:0] wptr;       // Oldest slot and next to be replaced
    logic [radar_pkg::BACKGROUND_DEPTH-1:0] filled;     // Slot holds a real sample
    logic [radar_pkg::SUM_BITS-1:0]         sum;        // Sum of all filled slots
    logic                                   model_full;
    radar_pkg::intensity_t                  intensity;  // Raw intensity of this point
    radar_pkg::intensity_t                  evicted;    // Sample leaving the window
    radar_pkg::intensity_t                  threshold;

    assign intensity  = in_point.attr.intensity;
    assign model_full = &filled;
    assign evicted    = filled[wptr] ? history[wptr] : '0;

    // Floor of the mean of the previous BACKGROUND_DEPTH intensities by shift
    assign threshold = model_full
                     ? sum[radar_pkg::SUM_BITS-1:radar_pkg::BACKGROUND_SHIFT]
                     : radar_pkg::DEFAULT_THRESHOLD;

    // ----------------------------------------------------------
    // Background model
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wptr   <= '0;
            filled <= '0;
            sum    <= '0;
        end else if (in_valid) begin
            sum          <= sum - evicted + intensity; // Ungated value enters the mean
            filled[wptr] <= 1'b1;
            wptr         <= wptr + 1'b1;               // Depth is a power of two
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            history[wptr] <= intensity;
        end
    end

    // ----------------------------------------------------------
    // Intensity gating
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clean_valid <= 1'b0;
            clean_point <= '0;
        end else begin
            clean_valid <= in_valid;
            if (in_valid) begin
                clean_point <= in_point; // Coordinates and phase pass unchanged
                if (intensity < threshold) begin
                    clean_point.attr.intensity <= '0; // Below background
                end
            end
        end
    end

    // Threshold uses the sum before this point is added, so a
    // point is never compared against its own intensity

endmodule

//--- source/median5.sv
`timescale 1ns/1ps

module median5 (
    input  radar_pkg::axis_samples_t samples,
    output radar_pkg::coord_t        median
);

    // Orders two entries of the network with the smaller value at index lo
    function automatic radar_pkg::axis_samples_t compare_exchange(
        input radar_pkg::axis_samples_t v,
        input int                       lo,
        input int                       hi
    );
        radar_pkg::axis_samples_t r;
        r = v;
        if ($signed(v[hi]) < $signed(v[lo])) begin
            r[lo] = v[hi];
            r[hi] = v[lo];
        end
        return r;
    endfunction

    radar_pkg::axis_samples_t net; // Working copy through the nine steps

    // ----------------------------------------------------------
    // Nine-step compare-exchange network
    // ----------------------------------------------------------
    always_comb begin
        net = samples;
        net = compare_exchange(net, 0, 1); // Pair the two oldest
        net = compare_exchange(net, 3, 4); // Pair the two newest
        net = compare_exchange(net, 2, 4);
        net = compare_exchange(net, 2, 3); // Slots 2..4 now ordered
        net = compare_exchange(net, 1, 4); // Largest settles in slot 4
        net = compare_exchange(net, 0, 3);
        net = compare_exchange(net, 0, 2); // Smallest settles in slot 0
        net = compare_exchange(net, 1, 3);
        net = compare_exchange(net, 1, 2); // Middle value lands in slot 2
        median = net[2];
    end

    // Only slot 2 is fully ordered at the end; the outer slots
    // are bounds and not a complete sort

endmodule

//--- source/point_window.sv
`timescale 1ns/1ps

module point_window (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  radar_pkg::point_t  in_point,
    output radar_pkg::window_t window,
    output logic               window_valid
);

    logic [radar_pkg::FILL_BITS-1:0]             fill_count;  // Saturating count of points held
    logic                                        window_full; // Four older points present
    radar_pkg::coord_t [radar_pkg::NUM_AXES-1:0] new_coords;  // Index 0 = X

    assign new_coords  = {in_point.z, in_point.y, in_point.x};
    assign window_full = (fill_count == radar_pkg::WINDOW_LEN - 1);

    // ----------------------------------------------------------
    // Fill tracking
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_count   <= '0;
            window_valid <= 1'b0;
        end else begin
            // The incoming point completes the window when four are already held
            window_valid <= in_valid && window_full;
            if (in_valid && !window_full) begin
                fill_count <= fill_count + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Sample shift register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int a = 0; a < radar_pkg::NUM_AXES; a++) begin
                for (int i = 0; i < radar_pkg::WINDOW_LEN - 1; i++) begin
                    window.axes[a][i] <= window.axes[a][i + 1]; // Age by one slot
                end
                window.axes[a][radar_pkg::WINDOW_LEN - 1] <= new_coords[a]; // Newest last
            end
            window.attr <= in_point.attr; // Attribute follows the newest point
        end
    end

    // Idle cycles leave the window untouched, so gaps between
    // points do not disturb the median history

endmodule

//--- source/radar_pkg.sv
package radar_pkg;

    // ----------------------------------------------------------
    // Scalar types
    // ----------------------------------------------------------
    typedef logic signed [31:0] coord_t;     // One signed coordinate
    typedef logic [15:0]        intensity_t; // Raw or gated intensity
    typedef logic [15:0]        phase_t;     // Phase wraps modulo 2^16
    typedef logic signed [15:0] velocity_t;  // Signed radial velocity

    // ----------------------------------------------------------
    // Design constants
    // ----------------------------------------------------------
    localparam int WINDOW_LEN       = 5;  // Points in the median window
    localparam int NUM_AXES         = 3;  // X, Y and Z
    localparam int BACKGROUND_DEPTH = 16; // Intensities in the background mean
    localparam int BACKGROUND_SHIFT = 4;  // log2 of BACKGROUND_DEPTH
    localparam int VELOCITY_BITS    = 8;  // Low phase-difference bits used as velocity

    localparam intensity_t DEFAULT_THRESHOLD = 16'h00FF; // Until the model is full

    // Fill counter saturates at WINDOW_LEN-1
    localparam int FILL_BITS = $clog2(WINDOW_LEN);
    // Wide enough for BACKGROUND_DEPTH full-scale intensities
    localparam int SUM_BITS  = $bits(intensity_t) + BACKGROUND_SHIFT;

    // ----------------------------------------------------------
    // Point formats
    // ----------------------------------------------------------
    typedef struct packed {
        phase_t     phase;     // Upper half of the attribute word
        intensity_t intensity; // Lower half
    } attr_t;

    typedef struct packed {
        attr_t  attr;
        coord_t z;
        coord_t y;
        coord_t x;             // Low 32 bits
    } point_t;

    // Five samples of one axis with the oldest at index 0
    typedef coord_t [WINDOW_LEN-1:0] axis_samples_t;

    typedef struct packed {
        attr_t                        attr; // Attribute of the newest point
        axis_samples_t [NUM_AXES-1:0] axes; // 0 = X, 1 = Y, 2 = Z
    } window_t;

    typedef struct packed {
        velocity_t  velocity;
        intensity_t intensity; // After clutter gating
        coord_t     z;
        coord_t     y;
        coord_t     x;
    } cloud_point_t;

endpackage
